// File: reflex_loop.f
+incdir+include
rtl/reflex_pkg.sv
rtl/param_bank.sv
rtl/sim_tick_gen.sv
rtl/spike_counter.sv
rtl/syn_current.sv
rtl/readback_mux.sv
rtl/reflex_loop_top.sv
testbench/reflex_checker.sv
testbench/tb_reflex_loop.sv

// File: testbench/tb_reflex_loop.sv
`timescale 1ns/1ps
`include "reflex_cfg.svh"

module tb_reflex_loop;
    import reflex_pkg::*;

    // spike source modes
    localparam logic [1:0] SPK_OFF  = 2'd0;
    localparam logic [1:0] SPK_ALL  = 2'd1;
    localparam logic [1:0] SPK_PER  = 2'd2;
    localparam logic [1:0] SPK_LFSR = 2'd3;
    localparam int N_ROWS  = 5;
    localparam int N_READS = 8;
    localparam rd_addr_t IDLE_ADDR = 8'h00;
    localparam trig_vec_t KNOWN_TRIG = (16'd1 << `TRIG_HALF_CNT) | (16'd1 << `TRIG_SYN_GAIN);

    // one stimulus row
    typedef struct packed {
        logic [95:0]  name;
        trig_vec_t    trig;
        param_word_t  half;
        param_word_t  gain;
        logic [1:0]   sn_mode;
        logic [7:0]   sn_per;
        logic [1:0]   mn_mode;
        logic [7:0]   mn_per;
        logic [7:0]   windows;
        spike_count_t exp_mn;
    } row_t;

    logic         ep50trig;
    logic         reset_sim;
    half_word_t   wire_lo;
    half_word_t   wire_hi;
    trig_vec_t    trig;
    logic         sn_spike;
    logic         mn_spike;
    rd_addr_t     rd_addr;
    half_word_t   rd_data;
    logic [95:0]  cur_name;
    spike_count_t exp_mn;
    logic [31:0]  err_cnt;
    logic [31:0]  chk_cnt;
    row_t         rows [N_ROWS];
    rd_addr_t     rd_list [N_READS];
    logic [31:0]  lfsr;
    param_word_t  eff_half;
    int           limit_cycles = 0;
    int           budget;
    int           run_len;
    int           r;
    int           c;

    always #5 ep50trig = ~ep50trig;

    reflex_loop_top u_dut
    (
        .ep50trig  (ep50trig),
        .reset_sim (reset_sim),
        .i_wire_lo (wire_lo),
        .i_wire_hi (wire_hi),
        .i_trig    (trig),
        .i_sn_spike(sn_spike),
        .i_mn_spike(mn_spike),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data)
    );

    reflex_checker u_checker
    (
        .ep50trig   (ep50trig),
        .reset_sim  (reset_sim),
        .i_wire_lo  (wire_lo),
        .i_wire_hi  (wire_hi),
        .i_trig     (trig),
        .i_sn_spike (sn_spike),
        .i_mn_spike (mn_spike),
        .i_rd_addr  (rd_addr),
        .i_rd_data  (rd_data),
        .i_exp_mn   (exp_mn),
        .i_test_name(cur_name),
        .o_errors   (err_cnt),
        .o_checks   (chk_cnt)
    );

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////

    // galois step for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one spike bit for this cycle of the row
    function automatic logic spike_bit(input logic [1:0] mode, input logic [7:0] per,
                                       input int cyc);
        case (mode)
            SPK_ALL: spike_bit = 1'b1;
            SPK_PER: spike_bit = ((cyc % per) == 0);
            SPK_LFSR:
            begin
                lfsr = lfsr_step(lfsr);
                spike_bit = lfsr[0];
            end
            default: spike_bit = 1'b0;
        endcase
    endfunction

    // one-cycle strobe with the word split into halves
    task automatic host_write(input trig_vec_t strobe, input param_word_t data);
        @(posedge ep50trig);
        wire_lo <= data[15:0];
        wire_hi <= data[31:16];
        trig <= strobe;
        @(posedge ep50trig);
        trig <= '0;
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial
    begin
        ep50trig = 1'b0;
        reset_sim = 1'b1;
        wire_lo = '0;
        wire_hi = '0;
        trig = '0;
        sn_spike = 1'b0;
        mn_spike = 1'b0;
        rd_addr = IDLE_ADDR;
        cur_name = "reset";
        exp_mn = '0;
        lfsr = 32'h4b77;
        // name, trig, half, gain, sn mode/period, mn mode/period, windows, motor count
        rows[0] = '{"defaults", 16'h0000, 32'd0, 32'd0, SPK_OFF, 8'd1, SPK_ALL, 8'd1,
                    8'd3, 32'd10};
        rows[1] = '{"half_load", 16'h0001, 32'd19, 32'd0, SPK_PER, 8'd4, SPK_ALL, 8'd1,
                    8'd3, 32'd20};
        rows[2] = '{"lfsr_spikes", 16'h0000, 32'd0, 32'd0, SPK_LFSR, 8'd1, SPK_PER, 8'd5,
                    8'd4, 32'd4};
        rows[3] = '{"neg_gain", 16'h0041, 32'd7, 32'hffff_fffd, SPK_LFSR, 8'd1, SPK_OFF,
                    8'd1, 8'd6, 32'd0};
        rows[4] = '{"junk_trig", 16'hffbe, 32'd0, 32'd0, SPK_PER, 8'd2, SPK_ALL, 8'd1,
                    8'd3, 32'd8};
        // the last two are unmapped endpoints
        rd_list = '{`RD_SYN_LO, `RD_SYN_HI, `RD_SN_LO, `RD_SN_HI, `RD_MN_LO, `RD_MN_HI,
                    8'h22, 8'hff};
        // watchdog budget from windows, reads and writes
        budget = 3;
        eff_half = `HALF_CNT_RESET;
        for (r = 0; r < N_ROWS; r++)
        begin
            if (rows[r].trig[`TRIG_HALF_CNT])
            begin
                eff_half = rows[r].half;
            end
            budget = budget + rows[r].windows * (eff_half + 1) + N_READS + 7;
        end
        limit_cycles = 2 * budget;
        repeat (3) @(posedge ep50trig);
        reset_sim <= 1'b0;
        eff_half = `HALF_CNT_RESET;
        for (r = 0; r < N_ROWS; r++)
        begin
            cur_name <= rows[r].name;
            exp_mn <= rows[r].exp_mn;
            if (rows[r].trig[`TRIG_HALF_CNT])
            begin
                host_write(16'd1 << `TRIG_HALF_CNT, rows[r].half);
                eff_half = rows[r].half;
            end
            if (rows[r].trig[`TRIG_SYN_GAIN])
            begin
                host_write(16'd1 << `TRIG_SYN_GAIN, rows[r].gain);
            end
            // strobes with no register behind them
            if ((rows[r].trig & ~KNOWN_TRIG) != '0)
            begin
                host_write(rows[r].trig & ~KNOWN_TRIG, 32'hdead_beef);
            end
            // spikes keep running through the reads
            // two idle cycles let the last read land inside the row
            run_len = rows[r].windows * (eff_half + 1);
            for (c = 0; c < run_len + N_READS + 2; c++)
            begin
                @(posedge ep50trig);
                sn_spike <= spike_bit(rows[r].sn_mode, rows[r].sn_per, c);
                mn_spike <= spike_bit(rows[r].mn_mode, rows[r].mn_per, c);
                if (c >= run_len && c < run_len + N_READS)
                begin
                    rd_addr <= rd_list[c - run_len];
                end
                else
                begin
                    rd_addr <= IDLE_ADDR;
                end
            end
        end
        repeat (2) @(posedge ep50trig);
        $display("errors %0d, checks %0d", err_cnt, chk_cnt);
        if (err_cnt == 0 && chk_cnt > 0)
        begin
            $display("ALL TESTS PASSED");
        end
        else
        begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog at twice the expected run length
    initial
    begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge ep50trig);
        $display("watchdog expired after %0d cycles, stimulus never finished", limit_cycles);
        $display("errors %0d, checks %0d", err_cnt, chk_cnt);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: testbench/reflex_checker.sv
`timescale 1ns/1ps
`include "reflex_cfg.svh"

module reflex_checker
(
    input  logic                     ep50trig,
    input  logic                     reset_sim,
    input  reflex_pkg::half_word_t   i_wire_lo,
    input  reflex_pkg::half_word_t   i_wire_hi,
    input  reflex_pkg::trig_vec_t    i_trig,
    input  logic                     i_sn_spike,
    input  logic                     i_mn_spike,
    input  reflex_pkg::rd_addr_t     i_rd_addr,
    input  reflex_pkg::half_word_t   i_rd_data,
    input  reflex_pkg::spike_count_t i_exp_mn,
    input  logic [95:0]              i_test_name,
    output logic [31:0]              o_errors,
    output logic [31:0]              o_checks
);
    import reflex_pkg::*;

    // model parameters loaded from observed strobes
    param_word_t  half_m;
    gain_t        gain_m;
    // model time base and counts
    param_word_t  cnt_m;
    logic         tick_m;
    spike_count_t sn_run;
    spike_count_t sn_out;
    spike_count_t mn_run;
    spike_count_t mn_out;
    // model synapse
    current_t     cur_m;
    current_t     leak_m;
    current_t     scaled_m;
    // expected readback and the address it belongs to
    half_word_t   rd_exp;
    rd_addr_t     addr_q;
    half_word_t   tbl_half;
    int           error_cnt = 0;
    int           check_cnt = 0;

    assign o_errors = error_cnt;
    assign o_checks = check_cnt;

    //////////////////////////////
    // reference model
    //////////////////////////////
    always @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            half_m <= `HALF_CNT_RESET;
            gain_m <= `SYN_GAIN_RESET;
            cnt_m <= '0;
            sn_run <= '0;
            sn_out <= '0;
            mn_run <= '0;
            mn_out <= '0;
            cur_m <= '0;
            scaled_m <= '0;
            rd_exp <= '0;
            addr_q <= '0;
        end
        else
        begin
            // window ends once the count reaches the half count
            tick_m = (cnt_m >= half_m);
            leak_m = tick_m ? cur_m - (cur_m >>> `SYN_DECAY_SHIFT) : cur_m;
            if (i_trig[`TRIG_HALF_CNT])
            begin
                half_m <= {i_wire_hi, i_wire_lo};
            end
            if (i_trig[`TRIG_SYN_GAIN])
            begin
                gain_m <= {i_wire_hi, i_wire_lo};
            end
            cnt_m <= tick_m ? '0 : cnt_m + 32'd1;
            sn_run <= tick_m ? '0 : sn_run + i_sn_spike;
            mn_run <= tick_m ? '0 : mn_run + i_mn_spike;
            if (tick_m)
            begin
                sn_out <= sn_run + i_sn_spike;
                mn_out <= mn_run + i_mn_spike;
            end
            // leak then inject
            // product keeps its low word
            cur_m <= i_sn_spike ? leak_m + `SYN_WEIGHT : leak_m;
            scaled_m <= cur_m * gain_m;
            addr_q <= i_rd_addr;
            case (i_rd_addr)
                `RD_SYN_LO: rd_exp <= scaled_m[15:0];
                `RD_SYN_HI: rd_exp <= scaled_m[31:16];
                `RD_SN_LO:  rd_exp <= sn_out[15:0];
                `RD_SN_HI:  rd_exp <= sn_out[31:16];
                `RD_MN_LO:  rd_exp <= mn_out[15:0];
                `RD_MN_HI:  rd_exp <= mn_out[31:16];
                default:    rd_exp <= '0;
            endcase
        end
    end

    //////////////////////////////
    // comparisons
    //////////////////////////////

    // readback is stable at the falling edge
    always @(negedge ep50trig)
    begin
        if (!reset_sim)
        begin
            check_cnt = check_cnt + 1;
            if (i_rd_data !== rd_exp)
            begin
                error_cnt = error_cnt + 1;
                $display("FAIL %0s: address %h expected %h actual %h",
                         i_test_name, addr_q, rd_exp, i_rd_data);
            end
            // motor count against the table value as well
            if (addr_q == `RD_MN_LO || addr_q == `RD_MN_HI)
            begin
                tbl_half = addr_q[0] ? i_exp_mn[31:16] : i_exp_mn[15:0];
                check_cnt = check_cnt + 1;
                if (i_rd_data !== tbl_half)
                begin
                    error_cnt = error_cnt + 1;
                    $display("FAIL %0s: motor count half %h expected %h actual %h",
                             i_test_name, addr_q, tbl_half, i_rd_data);
                end
            end
        end
    end

endmodule

// File: rtl/reflex_loop_top.sv
`timescale 1ns/1ps

module reflex_loop_top
(
    input  logic                   ep50trig,
    input  logic                   reset_sim,
    input  reflex_pkg::half_word_t i_wire_lo,
    input  reflex_pkg::half_word_t i_wire_hi,
    input  reflex_pkg::trig_vec_t  i_trig,
    input  logic                   i_sn_spike,
    input  logic                   i_mn_spike,
    input  reflex_pkg::rd_addr_t   i_rd_addr,
    output reflex_pkg::half_word_t o_rd_data
);
    import reflex_pkg::*;

    // parameters out of the host bank
    param_word_t  half_cnt;
    gain_t        syn_gain;
    // shared simulation time base
    logic         sim_tick;
    // results for readback
    spike_count_t sn_count;
    spike_count_t mn_count;
    current_t     syn_scaled;

    //////////////////////////////
    // host parameters and tick
    //////////////////////////////
    param_bank u_param_bank
    (
        .ep50trig   (ep50trig),
        .reset_sim  (reset_sim),
        .i_wire_lo  (i_wire_lo),
        .i_wire_hi  (i_wire_hi),
        .i_trig     (i_trig),
        .o_half_cnt (half_cnt),
        .o_syn_gain (syn_gain)
    );

    sim_tick_gen u_tick_gen
    (
        .ep50trig   (ep50trig),
        .reset_sim  (reset_sim),
        .i_half_cnt (half_cnt),
        .o_sim_tick (sim_tick)
    );

    //////////////////////////////
    // spike counts and synapse
    //////////////////////////////

    // sensory side
    spike_counter u_sn_count
    (
        .ep50trig   (ep50trig),
        .reset_sim  (reset_sim),
        .i_spike    (i_sn_spike),
        .i_sim_tick (sim_tick),
        .o_count    (sn_count)
    );

    // motor side
    spike_counter u_mn_count
    (
        .ep50trig   (ep50trig),
        .reset_sim  (reset_sim),
        .i_spike    (i_mn_spike),
        .i_sim_tick (sim_tick),
        .o_count    (mn_count)
    );

    // sensory spikes feed the synapse
    syn_current u_syn_current
    (
        .ep50trig     (ep50trig),
        .reset_sim    (reset_sim),
        .i_spike      (i_sn_spike),
        .i_sim_tick   (sim_tick),
        .i_syn_gain   (syn_gain),
        .o_syn_scaled (syn_scaled)
    );

    readback_mux u_readback
    (
        .ep50trig     (ep50trig),
        .reset_sim    (reset_sim),
        .i_rd_addr    (i_rd_addr),
        .i_syn_scaled (syn_scaled),
        .i_sn_count   (sn_count),
        .i_mn_count   (mn_count),
        .o_rd_data    (o_rd_data)
    );

endmodule

// File: rtl/readback_mux.sv
`timescale 1ns/1ps
`include "reflex_cfg.svh"

module readback_mux
(
    input  logic                     ep50trig,
    input  logic                     reset_sim,
    input  reflex_pkg::rd_addr_t     i_rd_addr,
    input  reflex_pkg::current_t     i_syn_scaled,
    input  reflex_pkg::spike_count_t i_sn_count,
    input  reflex_pkg::spike_count_t i_mn_count,
    output reflex_pkg::half_word_t   o_rd_data
);
    import reflex_pkg::*;

    // decoded half for the presented address
    half_word_t rd_sel;

    //////////////////////////////
    // endpoint decode
    //////////////////////////////

    // even address low half, odd address high half
    always_comb
    begin
        case (i_rd_addr)
            `RD_SYN_LO: rd_sel = i_syn_scaled[15:0];
            `RD_SYN_HI: rd_sel = i_syn_scaled[31:16];
            `RD_SN_LO:  rd_sel = i_sn_count[15:0];
            `RD_SN_HI:  rd_sel = i_sn_count[31:16];
            `RD_MN_LO:  rd_sel = i_mn_count[15:0];
            `RD_MN_HI:  rd_sel = i_mn_count[31:16];
            // unmapped endpoints read zero
            default:    rd_sel = '0;
        endcase
    end

    // data valid one cycle after the address
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            o_rd_data <= '0;
        end
        else
        begin
            o_rd_data <= rd_sel;
        end
    end

endmodule

// File: rtl/syn_current.sv
`timescale 1ns/1ps
`include "reflex_cfg.svh"

module syn_current
(
    input  logic                 ep50trig,
    input  logic                 reset_sim,
    input  logic                 i_spike,
    input  logic                 i_sim_tick,
    input  reflex_pkg::gain_t    i_syn_gain,
    output reflex_pkg::current_t o_syn_scaled
);
    import reflex_pkg::*;

    // synaptic current state
    current_t cur_q;
    // next current after leak and injection
    current_t cur_next;
    // full width product of current and gain
    logic signed [63:0] prod_full;

    //////////////////////////////
    // leak and inject
    //////////////////////////////

    // leak first on a tick
    // then a spike in the same cycle adds its charge
    always_comb
    begin
        cur_next = cur_q;
        if (i_sim_tick)
        begin
            cur_next = cur_q - (cur_q >>> `SYN_DECAY_SHIFT);
        end
        if (i_spike)
        begin
            cur_next = cur_next + `SYN_WEIGHT;
        end
    end

    // current moves only on tick or spike cycles
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            cur_q <= '0;
        end
        else if (i_sim_tick || i_spike)
        begin
            cur_q <= cur_next;
        end
    end

    //////////////////////////////
    // gain scaling
    //////////////////////////////

    // signed multiply with the low word kept
    assign prod_full = cur_q * i_syn_gain;

    // one register stage behind the current
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            o_syn_scaled <= '0;
        end
        else
        begin
            o_syn_scaled <= current_t'(prod_full[31:0]);
        end
    end

endmodule

// File: rtl/spike_counter.sv
`timescale 1ns/1ps

module spike_counter
(
    input  logic                     ep50trig,
    input  logic                     reset_sim,
    input  logic                     i_spike,
    input  logic                     i_sim_tick,
    output reflex_pkg::spike_count_t o_count
);
    import reflex_pkg::*;

    // running count inside the current window
    spike_count_t run_cnt;
    // running count with this cycle's spike folded in
    spike_count_t run_next;

    assign run_next = run_cnt + spike_count_t'(i_spike);

    //////////////////////////////
    // window accumulator
    //////////////////////////////

    // restart at zero after each tick
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            run_cnt <= '0;
        end
        else if (i_sim_tick)
        begin
            run_cnt <= '0;
        end
        else
        begin
            run_cnt <= run_next;
        end
    end

    // latch the complete window total
    // host never sees a partial count
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            o_count <= '0;
        end
        else if (i_sim_tick)
        begin
            o_count <= run_next;
        end
    end

endmodule

// File: rtl/sim_tick_gen.sv
`timescale 1ns/1ps

module sim_tick_gen
(
    input  logic                    ep50trig,
    input  logic                    reset_sim,
    input  reflex_pkg::param_word_t i_half_cnt,
    output logic                    o_sim_tick
);
    import reflex_pkg::*;

    // free running window counter
    param_word_t tick_cnt;

    // tick when the counter reaches the half count
    // greater-or-equal covers a half count lowered mid window
    assign o_sim_tick = (tick_cnt >= i_half_cnt);

    // counter wraps to 0 in the tick cycle
    // so one window spans half count plus one cycles
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            tick_cnt <= '0;
        end
        else if (o_sim_tick)
        begin
            tick_cnt <= '0;
        end
        else
        begin
            tick_cnt <= tick_cnt + 32'd1;
        end
    end

endmodule

// File: rtl/param_bank.sv
`timescale 1ns/1ps
`include "reflex_cfg.svh"

module param_bank
(
    input  logic                    ep50trig,
    input  logic                    reset_sim,
    input  reflex_pkg::half_word_t  i_wire_lo,
    input  reflex_pkg::half_word_t  i_wire_hi,
    input  reflex_pkg::trig_vec_t   i_trig,
    output reflex_pkg::param_word_t o_half_cnt,
    output reflex_pkg::gain_t       o_syn_gain
);
    import reflex_pkg::*;

    // assembled host word
    // high half sits above the low half
    param_word_t host_word;

    assign host_word = {i_wire_hi, i_wire_lo};

    //////////////////////////////
    // tick half count
    //////////////////////////////

    // loads on trigger bit 0
    // holds from the cycle after the strobe
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            o_half_cnt <= `HALF_CNT_RESET;
        end
        else if (i_trig[`TRIG_HALF_CNT])
        begin
            o_half_cnt <= host_word;
        end
    end

    //////////////////////////////
    // synaptic gain
    //////////////////////////////

    // loads on trigger bit 6
    // host word taken as a signed integer
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            o_syn_gain <= `SYN_GAIN_RESET;
        end
        else if (i_trig[`TRIG_SYN_GAIN])
        begin
            o_syn_gain <= gain_t'(host_word);
        end
    end

    // remaining trigger bits have no register here

endmodule

// File: rtl/reflex_pkg.sv
package reflex_pkg;

    // one host wire half
    typedef logic [15:0] half_word_t;

    // assembled unsigned parameter word
    typedef logic [31:0] param_word_t;

    // signed synaptic gain
    typedef logic signed [31:0] gain_t;

    // signed synaptic current
    typedef logic signed [31:0] current_t;

    // latched spike count for one window
    typedef logic [31:0] spike_count_t;

    // readback endpoint address
    typedef logic [7:0] rd_addr_t;

    // trigger strobe vector
    // one bit per parameter
    typedef logic [15:0] trig_vec_t;

endpackage

// File: include/reflex_cfg.svh
`ifndef REFLEX_CFG_SVH
`define REFLEX_CFG_SVH

//////////////////////////////
// parameter reset defaults
//////////////////////////////

// tick half count after reset
// period is half count plus one
`define HALF_CNT_RESET    32'd9
// unity synaptic gain
`define SYN_GAIN_RESET    32'sd1

// trigger strobe bit positions
`define TRIG_HALF_CNT     0
`define TRIG_SYN_GAIN     6

// synapse model constants
// charge injected per sensory spike
`define SYN_WEIGHT        32'sd1024
// leak per tick as arithmetic shift
`define SYN_DECAY_SHIFT   3

//////////////////////////////
// readback endpoint addresses
//////////////////////////////
`define RD_SYN_LO         8'h20
`define RD_SYN_HI         8'h21
`define RD_SN_LO          8'h24
`define RD_SN_HI          8'h25
`define RD_MN_LO          8'h26
`define RD_MN_HI          8'h27

`endif
